// File: files.f
verilog/intan_pkg.sv
verilog/lane_if.sv
verilog/acq_control.sv
verilog/frame_writer.sv
verilog/byte_fifo.sv
verilog/intan_acq.sv
dv/intan_acq_tb.sv

// File: Bender.yml
package:
  name: intan_acq

sources:
  - files:
      - verilog/intan_pkg.sv
      - verilog/lane_if.sv
      - verilog/acq_control.sv
      - verilog/frame_writer.sv
      - verilog/byte_fifo.sv
      - verilog/intan_acq.sv
  - target: test
    files:
      - dv/intan_acq_tb.sv

// File: dv/intan_acq_tb.sv
`timescale 1ns/1ps
`default_nettype none

module intan_acq_tb
    import intan_pkg::*;
();

    localparam int FRAME_BYTES = 960; // both lanes, all tests.
    localparam int CYCLE_LIMIT = FRAME_BYTES * 4 + 2000;

    logic        clk;
    logic        rst;
    dev_kind_t   dev_kind;
    logic [31:0] intan_id;
    logic        fs_read;
    logic        fd_read;
    logic        err;
    logic [1:0]  fifo_rxen = 2'b00;
    logic [15:0] fifo_rxd;
    logic [1:0]  fifo_empty;
    logic        fifo_full;
    logic [7:0]  so_fw1;
    logic [7:0]  so_fw0;

    logic [7:0] model_q [2][$];            // expected bytes, indexed by lane.
    logic [7:0] model_fc [2] = '{8'd0, 8'd0};
    logic [7:0] exp_byte [2];
    logic [1:0] chk = 2'b00;               // read issued last cycle.
    logic [1:0] drain_mode = 2'd0;         // off, every other cycle, random gaps.
    int         cyc = 0;
    int         start_cyc = 0;
    int         fd_count = 0;
    int         err_count = 0;
    int         errors = 0;
    int         test_errors = 0;
    int         fd_base = 0;
    int         err_base = 0;
    int         tests_run = 0;
    int         tests_failed = 0;

    intan_acq i_intan_acq (
        .clk        (clk),
        .rst        (rst),
        .dev_kind   (dev_kind),
        .intan_id   (intan_id),
        .fs_read    (fs_read),
        .fd_read    (fd_read),
        .err        (err),
        .fifo_rxen  (fifo_rxen),
        .fifo_rxd   (fifo_rxd),
        .fifo_empty (fifo_empty),
        .fifo_full  (fifo_full),
        .so_fw1     (so_fw1),
        .so_fw0     (so_fw0)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (!rst && fd_read) begin
            fd_count <= fd_count + 1;
        end
        if (!rst && err) begin
            err_count <= err_count + 1;
        end
        if (cyc >= CYCLE_LIMIT) begin
            $display("timeout: the DUT made no progress within %0d cycles", CYCLE_LIMIT);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // at most one read every other cycle, so rx_en never meets a fifo just emptied.
    always @(posedge clk) begin
        for (int l = 0; l < 2; l++) begin
            fifo_rxen[l] <= !rst && drain_mode != 2'd0 && !fifo_empty[l] && !fifo_rxen[l]
                && (drain_mode == 2'd1 || ($urandom % 4) != 0);
        end
    end

    always @(posedge clk) begin
        chk <= rst ? 2'b00 : fifo_rxen;
        for (int l = 0; l < 2; l++) begin
            if (!rst && fifo_rxen[l]) begin
                assert (model_q[l].size() > 0) else begin
                    errors++;
                    $display("lane %0d fifo returned a byte past the end of its frames", l);
                end
                if (model_q[l].size() > 0) begin
                    exp_byte[l] <= model_q[l].pop_front();
                end
            end
        end
    end

    for (genvar l = 0; l < 2; l++) begin : g_byte_check
        a_byte: assert property (@(posedge clk) disable iff (rst)
            chk[l] |-> fifo_rxd[8*l +: 8] == exp_byte[l])
            else begin
                errors++;
                $display("ERROR: fifo_rxd[%0d:%0d] = 0x%h, expected 0x%h", 8*l+7, 8*l,
                         $sampled(fifo_rxd[8*l +: 8]), $sampled(exp_byte[l]));
            end
    end

    function automatic int lane_len(input dev_kind_t kind, input int lane);
        case (kind)
            DEV_SINGLE_SMALL: return (lane == 1) ? 32 : 0;
            DEV_SINGLE_LARGE: return (lane == 1) ? 64 : 0;
            DEV_DUAL_LARGE:   return 64;
            default:          return 0;
        endcase
    endfunction

    // fs_read rise to fd_read rise.
    function automatic int done_latency(input dev_kind_t kind);
        int longest;
        longest = (lane_len(kind, 1) > lane_len(kind, 0)) ? lane_len(kind, 1) : lane_len(kind, 0);
        return 1 + (longest + 1) + 1; // start, lane done, merge.
    endfunction

    task automatic push_model(input dev_kind_t kind, input logic [31:0] id);
        int len;
        for (int l = 0; l < 2; l++) begin
            len = lane_len(kind, l);
            if (len > 0) begin
                model_q[l].push_back(id[16*l+8 +: 8]); // part number, high byte first.
                model_q[l].push_back(id[16*l +: 8]);
                for (int k = 0; k < len - 2; k++) begin
                    model_q[l].push_back(model_fc[l] + 8'(k));
                end
                model_fc[l] = model_fc[l] + 8'd1;
            end
        end
    endtask

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] want);
        assert (got === want) else begin
            errors++;
            $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, want);
        end
    endtask

    task automatic start_frame(input dev_kind_t kind);
        logic [31:0] id;
        id = $urandom;
        @(posedge clk);
        dev_kind  <= kind;
        intan_id  <= id;
        fs_read   <= 1'b1;
        start_cyc = cyc;
        push_model(kind, id);
        @(posedge clk);
        fs_read <= 1'b0;
    endtask

    task automatic wait_done(input bit check_lat, input int latency);
        @(posedge clk);
        while (fd_read !== 1'b1) begin
            @(posedge clk);
        end
        if (check_lat) begin
            expect_equal("fd_read latency", cyc - 1 - start_cyc, latency);
        end
    endtask

    task automatic drain_all();
        @(posedge clk);
        while (fifo_empty !== 2'b11 || fifo_rxen !== 2'b00 || chk !== 2'b00) begin
            @(posedge clk);
        end
        expect_equal("lane 1 model queue size", model_q[1].size(), 0);
        expect_equal("lane 0 model queue size", model_q[0].size(), 0);
    endtask

    task automatic run_frame(input dev_kind_t kind, input bit check_lat);
        start_frame(kind);
        wait_done(check_lat, done_latency(kind));
        drain_all();
    endtask

    task automatic begin_test();
        test_errors = errors;
        fd_base     = fd_count;
        err_base    = err_count;
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d, %s: ok", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d, %s: failed with %0d errors", tests_run, name,
                     errors - test_errors);
        end
    endtask

    initial begin
        void'($urandom(32'hb68efd2b));
        rst      = 1'b1;
        dev_kind = DEV_NONE;
        intan_id = '0;
        fs_read  = 1'b0;
        repeat (16) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);

        begin_test();
        expect_equal("fd_read", fd_read, 0);
        expect_equal("err", err, 0);
        expect_equal("fifo_full", fifo_full, 0);
        expect_equal("fifo_empty", fifo_empty, 2'b11);
        expect_equal("so_fw1", so_fw1, 0);
        expect_equal("so_fw0", so_fw0, 0);
        end_test("reset state");

        begin_test();
        drain_mode <= 2'd1;
        for (int i = 0; i < 4; i++) begin
            run_frame(dev_kind_t'(i), 1'b0);
        end
        expect_equal("fd_read pulses", fd_count - fd_base, 4);
        end_test("frame content per device kind");

        begin_test();
        run_frame(DEV_NONE, 1'b1);
        run_frame(DEV_SINGLE_SMALL, 1'b1);
        run_frame(DEV_DUAL_LARGE, 1'b1);
        expect_equal("fd_read pulses", fd_count - fd_base, 3);
        end_test("done timing");

        begin_test();
        drain_mode <= 2'd0;
        for (int i = 0; i < 2; i++) begin
            start_frame(DEV_DUAL_LARGE);
            wait_done(1'b1, done_latency(DEV_DUAL_LARGE));
        end
        start_frame(DEV_DUAL_LARGE); // stalls, both fifos hold two frames.
        repeat (10) @(posedge clk);
        expect_equal("fifo_full", fifo_full, 1);
        expect_equal("fd_read pulses", fd_count - fd_base, 2);
        drain_mode <= 2'd2;
        wait_done(1'b0, 0);
        drain_all();
        expect_equal("fd_read pulses", fd_count - fd_base, 3);
        drain_mode <= 2'd1;
        end_test("back-pressure");

        begin_test();
        run_frame(DEV_SINGLE_LARGE, 1'b1);
        expect_equal("so_fw1", so_fw1, model_fc[1]);
        expect_equal("so_fw0", so_fw0, model_fc[0]);
        end_test("frame counters");

        begin_test();
        start_frame(DEV_DUAL_LARGE);
        repeat (5) @(posedge clk);
        fs_read <= 1'b1; // second start in the middle of the frame.
        @(posedge clk);
        fs_read <= 1'b0;
        wait_done(1'b1, done_latency(DEV_DUAL_LARGE));
        drain_all();
        expect_equal("err pulses", err_count - err_base, 1);
        expect_equal("fd_read pulses", fd_count - fd_base, 1);
        end_test("busy start");

        $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/intan_acq.sv
`timescale 1ns/1ps
`default_nettype none

module intan_acq
    import intan_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  dev_kind_t   dev_kind,
    input  logic [31:0] intan_id,
    input  logic        fs_read,
    output logic        fd_read,
    output logic        err,
    input  logic [1:0]  fifo_rxen,
    output logic [15:0] fifo_rxd,
    output logic [1:0]  fifo_empty,
    output logic        fifo_full,
    output logic [7:0]  so_fw1,
    output logic [7:0]  so_fw0
);

    intan_id_u id_w;

    lane_if lane1 ();
    lane_if lane0 ();

    assign id_w.raw  = intan_id;
    assign fifo_full = lane1.full || lane0.full; // either lane stalls.

    acq_control i_acq_control (
        .clk      (clk),
        .rst      (rst),
        .dev_kind (dev_kind),
        .fs_read  (fs_read),
        .fd_read  (fd_read),
        .err      (err),
        .lane1    (lane1.ctrl),
        .lane0    (lane0.ctrl)
    );

    frame_writer i_writer1 (
        .clk         (clk),
        .rst         (rst),
        .part        (id_w.parts.part1),
        .lane        (lane1.writer),
        .frame_count (so_fw1)
    );

    frame_writer i_writer0 (
        .clk         (clk),
        .rst         (rst),
        .part        (id_w.parts.part0),
        .lane        (lane0.writer),
        .frame_count (so_fw0)
    );

    byte_fifo i_fifo1 (
        .clk   (clk),
        .rst   (rst),
        .lane  (lane1.fifo),
        .rx_en (fifo_rxen[1]),
        .rx_d  (fifo_rxd[15:8]),
        .empty (fifo_empty[1])
    );

    byte_fifo i_fifo0 (
        .clk   (clk),
        .rst   (rst),
        .lane  (lane0.fifo),
        .rx_en (fifo_rxen[0]),
        .rx_d  (fifo_rxd[7:0]),
        .empty (fifo_empty[0])
    );

endmodule

`default_nettype wire

// File: verilog/byte_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module byte_fifo
    import intan_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    lane_if.fifo       lane,
    input  logic       rx_en,
    output logic [7:0] rx_d,
    output logic       empty
);

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wptr;
    logic [FIFO_AW-1:0] rptr;
    logic [FIFO_AW:0]   count;
    logic               full;
    logic               do_wr;
    logic               do_rd;

    assign full  = (count == (FIFO_AW+1)'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign lane.full = full;

    assign do_wr = lane.wen && !full;
    assign do_rd = rx_en && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wptr  <= '0;
            rptr  <= '0;
            count <= '0;
        end else begin
            if (do_wr) begin
                wptr <= wptr + 1'b1; // wraps at depth.
            end
            if (do_rd) begin
                rptr <= rptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wptr] <= lane.wdata;
        end
    end

    // read data holds until the next read.
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rx_d <= mem[rptr];
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        lane.wen |-> !full);

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        rx_en |-> !empty);

endmodule

`default_nettype wire

// File: verilog/frame_writer.sv
`timescale 1ns/1ps
`default_nettype none

module frame_writer
    import intan_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic [15:0] part,
    lane_if.writer      lane,
    output logic [7:0]  frame_count
);

    logic       active;
    frame_len_t remaining;
    frame_len_t idx;
    frame_len_t pat_k;
    logic       wen;
    logic       done;
    logic [7:0] wdata;

    assign wen = active && !lane.full; // stall in place on full.

    assign lane.wen   = wen;
    assign lane.wdata = wdata;
    assign lane.done  = done;

    // header bytes first, then the counting test pattern.
    always_comb begin
        pat_k = idx - frame_len_t'(HDR_BYTES);
        if (idx == 12'd0) begin
            wdata = part[15:8];
        end else if (idx == 12'd1) begin
            wdata = part[7:0];
        end else begin
            wdata = frame_count + pat_k[7:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active      <= 1'b0;
            remaining   <= '0;
            idx         <= '0;
            done        <= 1'b0;
            frame_count <= '0;
        end else begin
            done <= 1'b0;
            if (lane.start && !active) begin
                idx       <= '0;
                remaining <= lane.len;
                if (lane.len == '0) begin
                    done <= 1'b1; // empty frame finishes at once.
                end else begin
                    active <= 1'b1;
                end
            end else if (wen) begin
                remaining <= remaining - 12'd1;
                idx       <= idx + 12'd1;
                if (remaining == 12'd1) begin
                    active      <= 1'b0;
                    done        <= 1'b1;
                    frame_count <= frame_count + 8'd1;
                end
            end
        end
    end

    a_no_wen_full: assert property (@(posedge clk) disable iff (rst)
        lane.wen |-> !lane.full);

endmodule

`default_nettype wire

// File: verilog/acq_control.sv
`timescale 1ns/1ps
`default_nettype none

module acq_control
    import intan_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  dev_kind_t dev_kind,
    input  logic      fs_read,
    output logic      fd_read,
    output logic      err,
    lane_if.ctrl      lane1,
    lane_if.ctrl      lane0
);

    frame_len_t len1_d;
    frame_len_t len0_d;
    logic       busy;
    logic       accept;
    logic       done1_q;
    logic       done0_q;
    logic       all_done;

    // length table per device kind.
    always_comb begin
        case (dev_kind)
            DEV_NONE: begin
                len1_d = '0;
                len0_d = '0;
            end
            DEV_SINGLE_SMALL: begin
                len1_d = LEN_SMALL;
                len0_d = '0;
            end
            DEV_SINGLE_LARGE: begin
                len1_d = LEN_LARGE;
                len0_d = '0;
            end
            DEV_DUAL_LARGE: begin
                len1_d = LEN_LARGE;
                len0_d = LEN_LARGE;
            end
            default: begin
                len1_d = '0;
                len0_d = '0;
            end
        endcase
    end

    assign accept   = fs_read && !busy;
    assign all_done = (done1_q || lane1.done) && (done0_q || lane0.done);

    always_ff @(posedge clk) begin
        if (rst) begin
            busy        <= 1'b0;
            done1_q     <= 1'b0;
            done0_q     <= 1'b0;
            fd_read     <= 1'b0;
            err         <= 1'b0;
            lane1.start <= 1'b0;
            lane0.start <= 1'b0;
            lane1.len   <= '0;
            lane0.len   <= '0;
        end else begin
            lane1.start <= accept;
            lane0.start <= accept;
            err         <= fs_read && busy; // start during a frame is dropped.
            fd_read     <= all_done;
            done1_q     <= !all_done && (done1_q || lane1.done);
            done0_q     <= !all_done && (done0_q || lane0.done);
            if (accept) begin
                busy      <= 1'b1;
                lane1.len <= len1_d; // frozen for the whole frame.
                lane0.len <= len0_d;
            end else if (all_done) begin
                busy <= 1'b0;
            end
        end
    end

    // a lane reports done only once per started frame.
    a_done1_busy: assert property (@(posedge clk) disable iff (rst)
        lane1.done |-> busy && !done1_q);
    a_done0_busy: assert property (@(posedge clk) disable iff (rst)
        lane0.done |-> busy && !done0_q);

    a_fd_single: assert property (@(posedge clk) disable iff (rst)
        fd_read |=> !fd_read);

endmodule

`default_nettype wire

// File: verilog/lane_if.sv
`timescale 1ns/1ps
`default_nettype none

interface lane_if
    import intan_pkg::*;
();

    logic       start; // frame start pulse.
    frame_len_t len;   // bytes in this frame.
    logic       done;  // frame done pulse.
    logic [7:0] wdata;
    logic       wen;
    logic       full;

    modport ctrl (
        output start,
        output len,
        input  done
    );

    modport writer (
        input  start,
        input  len,
        output done,
        output wdata,
        output wen,
        input  full
    );

    modport fifo (
        input  wdata,
        input  wen,
        output full
    );

endinterface

`default_nettype wire

// File: verilog/intan_pkg.sv
`default_nettype none

package intan_pkg;

    // attached headstage kind, as reported by the host.
    typedef enum logic [1:0] {
        DEV_NONE         = 2'b00,
        DEV_SINGLE_SMALL = 2'b01,
        DEV_SINGLE_LARGE = 2'b10,
        DEV_DUAL_LARGE   = 2'b11
    } dev_kind_t;

    // frame length in bytes.
    typedef logic [11:0] frame_len_t;

    localparam frame_len_t LEN_SMALL = 12'd32; // small device frame.
    localparam frame_len_t LEN_LARGE = 12'd64; // large device frame.

    // identifier bytes ahead of the samples.
    localparam int HDR_BYTES = 2;

    // per-lane fifo geometry.
    localparam int FIFO_DEPTH = 128;
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);

    // two part numbers packed into the id word, lane 1 on top.
    typedef struct packed {
        logic [15:0] part1;
        logic [15:0] part0;
    } intan_parts_t;

    typedef union packed {
        logic [31:0]  raw;
        intan_parts_t parts;
    } intan_id_u;

endpackage

`default_nettype wire
